// ==== Bender.yml ====
package:
  name: rob

sources:
  - logic/rob_pkg.sv
  - logic/rob_done_arbiter.sv
  - logic/rob_entry.sv
  - logic/rob_ctrl.sv
  - logic/rob_top.sv

  - target: test
    files:
      - tb/tb_rob.sv

// ==== compile.f ====
logic/rob_pkg.sv
logic/rob_done_arbiter.sv
logic/rob_entry.sv
logic/rob_ctrl.sv
logic/rob_top.sv
tb/tb_rob.sv

// ==== logic/rob_ctrl.sv ====
`timescale 1ns/1ns

module rob_ctrl #(
  parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH,
  parameter int DISP_SIZE = rob_pkg::DISP_SIZE
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_disp_valid,
  output logic                             o_disp_ready,

  output logic [ROB_DEPTH-1:0]             o_load_valid,
  input  logic [ROB_DEPTH-1:0]             i_entry_valid,
  input  logic [ROB_DEPTH-1:0]             i_entry_all_done,
  input  rob_pkg::pc_t                     i_entry_pc           [ROB_DEPTH],
  input  rob_pkg::grp_id_t                 i_entry_grp_id       [ROB_DEPTH],
  input  rob_pkg::grp_id_t                 i_entry_dead_grp     [ROB_DEPTH],
  input  rob_pkg::grp_id_t                 i_entry_except_valid [ROB_DEPTH],
  input  rob_pkg::cause_t [DISP_SIZE-1:0]  i_entry_except_cause [ROB_DEPTH],
  output logic [ROB_DEPTH-1:0]             o_commit_finish,
  output logic                             o_kill,

  output logic                             o_commit_valid,
  input  logic                             i_commit_ready,
  output rob_pkg::cmt_id_t                 o_commit_cmt_id,
  output rob_pkg::pc_t                     o_commit_pc,
  output rob_pkg::grp_id_t                 o_commit_grp_id,
  output rob_pkg::grp_id_t                 o_commit_dead_grp,
  output rob_pkg::grp_id_t                 o_commit_except_valid,
  output rob_pkg::cause_t                  o_commit_except_cause,
  output logic                             o_commit_flush
);
  import rob_pkg::*;

  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  ctrl_state_t            r_state;
  cmt_id_t                r_head;
  cmt_id_t                r_tail;
  logic [CNT_W-1:0]       r_count;

  logic                   w_disp_fire;
  logic                   w_commit_fire;
  cause_t [DISP_SIZE-1:0] w_head_causes;

  function automatic cmt_id_t f_next(input cmt_id_t ptr);
    return (ptr == cmt_id_t'(ROB_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_disp_ready  = (r_state == ST_RUN) & (r_count != CNT_W'(ROB_DEPTH));
  assign w_disp_fire   = i_disp_valid & o_disp_ready;
  assign w_commit_fire = o_commit_valid & i_commit_ready;
  assign o_kill        = (r_state == ST_FLUSH);

  always_comb begin
    for (int i = 0; i < ROB_DEPTH; i++) begin
      o_load_valid[i]    = w_disp_fire & (r_tail == cmt_id_t'(i));
      o_commit_finish[i] = w_commit_fire & (r_head == cmt_id_t'(i));
    end
  end

  // --------------------
  // Commit port
  // --------------------
  assign o_commit_valid        = (r_state == ST_RUN) & i_entry_all_done[r_head];
  assign o_commit_cmt_id       = r_head;
  assign o_commit_pc           = i_entry_pc[r_head];
  assign o_commit_grp_id       = i_entry_grp_id[r_head];
  assign o_commit_dead_grp     = i_entry_dead_grp[r_head];
  assign o_commit_except_valid = i_entry_except_valid[r_head];
  assign o_commit_flush        = o_commit_valid & (|o_commit_except_valid);
  assign w_head_causes         = i_entry_except_cause[r_head];

  // Oldest excepting slot wins
  always_comb begin
    o_commit_except_cause = '0;
    for (int d = DISP_SIZE - 1; d >= 0; d--) begin
      if (o_commit_except_valid[d]) begin
        o_commit_except_cause = w_head_causes[d];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= ST_RUN;
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= '0;
    end else if (r_state == ST_FLUSH) begin
      r_state <= ST_RUN;
      r_tail  <= r_head;   // Drop everything younger
      r_count <= '0;
    end else begin
      if (w_commit_fire && o_commit_flush) begin
        r_state <= ST_FLUSH;
      end
      if (w_disp_fire) begin
        r_tail <= f_next(r_tail);
      end
      if (w_commit_fire) begin
        r_head <= f_next(r_head);
      end
      r_count <= r_count + CNT_W'(w_disp_fire) - CNT_W'(w_commit_fire);
    end
  end

  // Occupancy count and entry valid bits must agree
  a_load_free: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_load_valid & i_entry_valid) == '0);

endmodule

// ==== logic/rob_done_arbiter.sv ====
`timescale 1ns/1ns

module rob_done_arbiter (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_done0_valid,
  output logic              o_done0_ready,
  input  rob_pkg::cmt_id_t  i_done0_cmt_id,
  input  rob_pkg::grp_id_t  i_done0_grp_id,
  input  logic              i_done0_except_valid,
  input  rob_pkg::cause_t   i_done0_except_cause,

  input  logic              i_done1_valid,
  output logic              o_done1_ready,
  input  rob_pkg::cmt_id_t  i_done1_cmt_id,
  input  rob_pkg::grp_id_t  i_done1_grp_id,
  input  logic              i_done1_except_valid,
  input  rob_pkg::cause_t   i_done1_except_cause,

  output logic              o_rpt_valid,
  output rob_pkg::cmt_id_t  o_rpt_cmt_id,
  output rob_pkg::grp_id_t  o_rpt_grp_id,
  output logic              o_rpt_except_valid,
  output rob_pkg::cause_t   o_rpt_except_cause
);

  logic r_prio;   // Set when pipe 1 wins the next tie
  logic w_gnt0;
  logic w_gnt1;
  logic w_contest;

  assign w_contest = i_done0_valid & i_done1_valid;
  assign w_gnt0    = i_done0_valid & (~i_done1_valid | ~r_prio);
  assign w_gnt1    = i_done1_valid & (~i_done0_valid | r_prio);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_prio <= 1'b0;
    end else if (w_contest) begin
      r_prio <= ~r_prio;
    end
  end

  assign o_done0_ready = w_gnt0;
  assign o_done1_ready = w_gnt1;

  // --------------------
  // Merged report
  // --------------------
  assign o_rpt_valid        = w_gnt0 | w_gnt1;
  assign o_rpt_cmt_id       = w_gnt1 ? i_done1_cmt_id       : i_done0_cmt_id;
  assign o_rpt_grp_id       = w_gnt1 ? i_done1_grp_id       : i_done0_grp_id;
  assign o_rpt_except_valid = w_gnt1 ? i_done1_except_valid : i_done0_except_valid;
  assign o_rpt_except_cause = w_gnt1 ? i_done1_except_cause : i_done0_except_cause;

  a_gnt_excl: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(o_done0_ready && o_done1_ready));

  // Entries decode one slot per report
  a_gnt0_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done0_ready |-> $onehot(i_done0_grp_id));
  a_gnt1_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_done1_ready |-> $onehot(i_done1_grp_id));

endmodule

// ==== logic/rob_entry.sv ====
`timescale 1ns/1ns

module rob_entry #(
  parameter int ENTRY_ID  = 0,
  parameter int DISP_SIZE = rob_pkg::DISP_SIZE
) (
  input  logic                             i_clk,
  input  logic                             i_reset_n,

  input  logic                             i_load_valid,
  input  rob_pkg::pc_t                     i_load_pc,
  input  rob_pkg::grp_id_t                 i_load_grp_id,
  input  rob_pkg::grp_id_t                 i_load_except_valid,
  input  rob_pkg::cause_t                  i_load_except_cause,

  input  logic                             i_rpt_valid,
  input  rob_pkg::cmt_id_t                 i_rpt_cmt_id,
  input  rob_pkg::grp_id_t                 i_rpt_grp_id,
  input  logic                             i_rpt_except_valid,
  input  rob_pkg::cause_t                  i_rpt_except_cause,

  input  logic                             i_commit_finish,
  input  logic                             i_kill,

  output logic                             o_valid,
  output logic                             o_block_all_done,
  output rob_pkg::pc_t                     o_pc,
  output rob_pkg::grp_id_t                 o_grp_id,
  output rob_pkg::grp_id_t                 o_dead_grp,
  output rob_pkg::grp_id_t                 o_except_valid,
  output rob_pkg::cause_t [DISP_SIZE-1:0]  o_except_cause
);
  import rob_pkg::*;

  logic                   r_valid;
  pc_t                    r_pc;
  grp_id_t                r_grp_id;
  grp_id_t                r_done;
  grp_id_t                r_dead;
  grp_id_t                r_except_valid;
  cause_t [DISP_SIZE-1:0] r_except_cause;

  grp_id_t w_load_exc_raw;
  grp_id_t w_load_kill;
  grp_id_t w_load_exc;
  logic    w_rpt_hit;
  grp_id_t w_rpt_slot;
  grp_id_t w_rpt_live;   // Reported slot that is still alive
  grp_id_t w_rpt_exc;
  grp_id_t w_rpt_kill;

  // Every bit at or above the lowest set bit
  function automatic grp_id_t f_fill_up(input grp_id_t seed);
    grp_id_t res;
    res[0] = seed[0];
    for (int i = 1; i < DISP_SIZE; i++) begin
      res[i] = res[i-1] | seed[i];
    end
    return res;
  endfunction

  // --------------------
  // Dispatch exceptions
  // --------------------
  assign w_load_exc_raw = i_load_except_valid & i_load_grp_id;
  assign w_load_kill    = f_fill_up(w_load_exc_raw << 1) & i_load_grp_id;
  assign w_load_exc     = w_load_exc_raw & ~w_load_kill;

  // --------------------
  // Completion match
  // --------------------
  assign w_rpt_hit  = i_rpt_valid & (i_rpt_cmt_id == cmt_id_t'(ENTRY_ID));
  assign w_rpt_slot = i_rpt_grp_id & {DISP_SIZE{w_rpt_hit}};
  assign w_rpt_live = w_rpt_slot & ~r_dead;
  assign w_rpt_exc  = w_rpt_live & {DISP_SIZE{i_rpt_except_valid}};

  // Younger slots of the same group die behind an exception
  assign w_rpt_kill = f_fill_up(w_rpt_exc << 1) & r_grp_id;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid        <= 1'b0;
      r_grp_id       <= '0;
      r_done         <= '0;
      r_dead         <= '0;
      r_except_valid <= '0;
    end else if (i_load_valid) begin
      r_valid        <= 1'b1;
      r_grp_id       <= i_load_grp_id;
      r_done         <= w_load_exc;   // Excepted at dispatch, nothing to execute
      r_dead         <= w_load_kill;
      r_except_valid <= w_load_exc;
    end else if (r_valid) begin
      if (i_commit_finish || i_kill) begin
        r_valid <= 1'b0;
      end
      r_done         <= r_done | w_rpt_slot;
      r_dead         <= r_dead | w_rpt_kill;
      r_except_valid <= (r_except_valid & ~w_rpt_live & ~w_rpt_kill) | w_rpt_exc;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_load_valid) begin
      r_pc <= i_load_pc;
      for (int d = 0; d < DISP_SIZE; d++) begin
        r_except_cause[d] <= i_load_except_cause;
      end
    end else begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_rpt_live[d]) begin
          r_except_cause[d] <= i_rpt_except_cause;
        end
      end
    end
  end

  assign o_valid          = r_valid;
  assign o_block_all_done = r_valid & (((r_done | r_dead) & r_grp_id) == r_grp_id);
  assign o_pc             = r_pc;
  assign o_grp_id         = r_grp_id;
  assign o_dead_grp       = r_dead;
  assign o_except_valid   = r_except_valid;
  assign o_except_cause   = r_except_cause;

  // Pipes only report groups that are still in flight
  a_rpt_to_valid: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    w_rpt_hit |-> r_valid);

endmodule

// ==== logic/rob_pkg.sv ====
package rob_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int DISP_SIZE = 2;   // Slots per dispatch group
  localparam int ROB_DEPTH = 4;   // Group entries
  localparam int CMT_ID_W  = 2;
  localparam int PC_W      = 32;
  localparam int CAUSE_W   = 4;

  // --------------------
  // Types
  // --------------------

  // Slot mask, or one-hot slot select in a completion report
  typedef logic [DISP_SIZE-1:0] grp_id_t;

  typedef logic [CMT_ID_W-1:0] cmt_id_t;
  typedef logic [PC_W-1:0]     pc_t;
  typedef logic [CAUSE_W-1:0]  cause_t;

  // --------------------
  // Exception causes
  // --------------------
  localparam cause_t CAUSE_ILLEGAL     = 4'd2;
  localparam cause_t CAUSE_LOAD_FAULT  = 4'd5;
  localparam cause_t CAUSE_STORE_FAULT = 4'd7;

  // Commit controller
  typedef enum logic {
    ST_RUN,
    ST_FLUSH    // One cycle of kill after an excepting commit
  } ctrl_state_t;

endpackage

// ==== logic/rob_top.sv ====
`timescale 1ns/1ns

module rob_top #(
  parameter int ROB_DEPTH = rob_pkg::ROB_DEPTH,
  parameter int DISP_SIZE = rob_pkg::DISP_SIZE
) (
  input  logic              i_clk,
  input  logic              i_reset_n,

  input  logic              i_disp_valid,
  output logic              o_disp_ready,
  input  rob_pkg::pc_t      i_disp_pc,
  input  rob_pkg::grp_id_t  i_disp_grp_id,
  input  rob_pkg::grp_id_t  i_disp_except_valid,
  input  rob_pkg::cause_t   i_disp_except_cause,

  input  logic              i_done0_valid,
  output logic              o_done0_ready,
  input  rob_pkg::cmt_id_t  i_done0_cmt_id,
  input  rob_pkg::grp_id_t  i_done0_grp_id,
  input  logic              i_done0_except_valid,
  input  rob_pkg::cause_t   i_done0_except_cause,

  input  logic              i_done1_valid,
  output logic              o_done1_ready,
  input  rob_pkg::cmt_id_t  i_done1_cmt_id,
  input  rob_pkg::grp_id_t  i_done1_grp_id,
  input  logic              i_done1_except_valid,
  input  rob_pkg::cause_t   i_done1_except_cause,

  output logic              o_commit_valid,
  input  logic              i_commit_ready,
  output rob_pkg::cmt_id_t  o_commit_cmt_id,
  output rob_pkg::pc_t      o_commit_pc,
  output rob_pkg::grp_id_t  o_commit_grp_id,
  output rob_pkg::grp_id_t  o_commit_dead_grp,
  output rob_pkg::grp_id_t  o_commit_except_valid,
  output rob_pkg::cause_t   o_commit_except_cause,
  output logic              o_commit_flush
);
  import rob_pkg::*;

  // Merged completion bus
  logic    w_rpt_valid;
  cmt_id_t w_rpt_cmt_id;
  grp_id_t w_rpt_grp_id;
  logic    w_rpt_except_valid;
  cause_t  w_rpt_except_cause;

  // Per-entry state toward the controller
  logic [ROB_DEPTH-1:0]   w_load_valid;
  logic [ROB_DEPTH-1:0]   w_commit_finish;
  logic                   w_kill;
  logic [ROB_DEPTH-1:0]   w_entry_valid;
  logic [ROB_DEPTH-1:0]   w_entry_all_done;
  pc_t                    w_entry_pc           [ROB_DEPTH];
  grp_id_t                w_entry_grp_id       [ROB_DEPTH];
  grp_id_t                w_entry_dead_grp     [ROB_DEPTH];
  grp_id_t                w_entry_except_valid [ROB_DEPTH];
  cause_t [DISP_SIZE-1:0] w_entry_except_cause [ROB_DEPTH];

  rob_done_arbiter u_arb (
    .i_clk, .i_reset_n,
    .i_done0_valid, .o_done0_ready, .i_done0_cmt_id, .i_done0_grp_id,
    .i_done0_except_valid, .i_done0_except_cause,
    .i_done1_valid, .o_done1_ready, .i_done1_cmt_id, .i_done1_grp_id,
    .i_done1_except_valid, .i_done1_except_cause,
    .o_rpt_valid        (w_rpt_valid),
    .o_rpt_cmt_id       (w_rpt_cmt_id),
    .o_rpt_grp_id       (w_rpt_grp_id),
    .o_rpt_except_valid (w_rpt_except_valid),
    .o_rpt_except_cause (w_rpt_except_cause)
  );

  rob_ctrl #(.ROB_DEPTH(ROB_DEPTH), .DISP_SIZE(DISP_SIZE)) u_ctrl (
    .i_clk, .i_reset_n, .i_disp_valid, .o_disp_ready,
    .o_load_valid         (w_load_valid),
    .i_entry_valid        (w_entry_valid),
    .i_entry_all_done     (w_entry_all_done),
    .i_entry_pc           (w_entry_pc),
    .i_entry_grp_id       (w_entry_grp_id),
    .i_entry_dead_grp     (w_entry_dead_grp),
    .i_entry_except_valid (w_entry_except_valid),
    .i_entry_except_cause (w_entry_except_cause),
    .o_commit_finish      (w_commit_finish),
    .o_kill               (w_kill),
    .o_commit_valid, .i_commit_ready, .o_commit_cmt_id, .o_commit_pc,
    .o_commit_grp_id, .o_commit_dead_grp, .o_commit_except_valid,
    .o_commit_except_cause, .o_commit_flush
  );

  for (genvar g = 0; g < ROB_DEPTH; g++) begin : g_entry
    rob_entry #(.ENTRY_ID(g), .DISP_SIZE(DISP_SIZE)) u_entry (
      .i_clk, .i_reset_n,
      .i_load_valid        (w_load_valid[g]),
      .i_load_pc           (i_disp_pc),
      .i_load_grp_id       (i_disp_grp_id),
      .i_load_except_valid (i_disp_except_valid),
      .i_load_except_cause (i_disp_except_cause),
      .i_rpt_valid         (w_rpt_valid),
      .i_rpt_cmt_id        (w_rpt_cmt_id),
      .i_rpt_grp_id        (w_rpt_grp_id),
      .i_rpt_except_valid  (w_rpt_except_valid),
      .i_rpt_except_cause  (w_rpt_except_cause),
      .i_commit_finish     (w_commit_finish[g]),
      .i_kill              (w_kill),
      .o_valid             (w_entry_valid[g]),
      .o_block_all_done    (w_entry_all_done[g]),
      .o_pc                (w_entry_pc[g]),
      .o_grp_id            (w_entry_grp_id[g]),
      .o_dead_grp          (w_entry_dead_grp[g]),
      .o_except_valid      (w_entry_except_valid[g]),
      .o_except_cause      (w_entry_except_cause[g])
    );
  end

endmodule

// ==== tb/tb_rob.sv ====
`timescale 1ns/1ns

module tb_rob;
  import rob_pkg::*;

  localparam int TIMEOUT = 300;   // Cycles per wait

  typedef struct packed {
    cmt_id_t                cmt;
    pc_t                    pc;
    grp_id_t                grp;
    grp_id_t                dead;
    grp_id_t                exc;
    grp_id_t                pend;   // Slots whose report the DUT has not taken yet
    cause_t [DISP_SIZE-1:0] causes;
  } exp_t;

  typedef struct packed {
    cmt_id_t cmt;
    grp_id_t slot;
    logic    exc;
    cause_t  cause;
  } rpt_t;

  logic    i_clk, i_reset_n;
  logic    i_disp_valid, o_disp_ready;
  pc_t     i_disp_pc;
  grp_id_t i_disp_grp_id, i_disp_except_valid;
  cause_t  i_disp_except_cause;
  logic    i_done0_valid, o_done0_ready, i_done0_except_valid;
  cmt_id_t i_done0_cmt_id;
  grp_id_t i_done0_grp_id;
  cause_t  i_done0_except_cause;
  logic    i_done1_valid, o_done1_ready, i_done1_except_valid;
  cmt_id_t i_done1_cmt_id;
  grp_id_t i_done1_grp_id;
  cause_t  i_done1_except_cause;
  logic    o_commit_valid, i_commit_ready, o_commit_flush;
  cmt_id_t o_commit_cmt_id;
  pc_t     o_commit_pc;
  grp_id_t o_commit_grp_id, o_commit_dead_grp, o_commit_except_valid;
  cause_t  o_commit_except_cause;

  exp_t        exp_q[$];        // Dispatched groups, oldest first
  exp_t        exp_head;
  cause_t      exp_cause;
  logic        exp_flush;
  rpt_t        pipe0_q[$];
  rpt_t        pipe1_q[$];
  int          m_count, m_tail;
  logic        m_in_flush;
  int          err_count, test_err_start, tests_run, tests_failed;
  bit          aborted;
  logic [31:0] lfsr_state;

  rob_top #(.ROB_DEPTH(ROB_DEPTH), .DISP_SIZE(DISP_SIZE)) u_dut (.*);

  always #20 i_clk = ~i_clk;

  // --------------------
  // Model
  // --------------------
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic void refresh_head();
    exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    m_count = exp_q.size();
    exp_cause = '0;
    for (int s = DISP_SIZE - 1; s >= 0; s--) begin
      if (exp_head.exc[s]) exp_cause = exp_head.causes[s];   // Lowest slot wins
    end
    exp_flush = |exp_head.exc;
  endfunction

  function automatic exp_t expected_on_dispatch(input pc_t pc, input grp_id_t grp,
                                                input grp_id_t exc_mask, input cause_t cause);
    exp_t e;
    e = '0;
    e.cmt = cmt_id_t'(m_tail);
    e.pc = pc;
    e.grp = grp;
    for (int s = 0; s < DISP_SIZE; s++) begin
      e.causes[s] = cause;
      if (grp[s] && exc_mask[s] && e.exc == '0) begin
        e.exc[s] = 1'b1;
        for (int t = s + 1; t < DISP_SIZE; t++) e.dead[t] = grp[t];   // Younger slots die
      end
    end
    return e;
  endfunction

  function automatic void apply_report(input rpt_t r);
    exp_t e;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].cmt == r.cmt) begin
        e = exp_q[i];
        e.pend = e.pend | r.slot;
        for (int s = 0; s < DISP_SIZE; s++) begin
          if (r.slot[s] && !e.dead[s]) begin
            e.exc[s] = r.exc;
            e.causes[s] = r.cause;
            for (int t = s + 1; t < DISP_SIZE; t++) begin
              if (r.exc && e.grp[t]) begin
                e.dead[t] = 1'b1;
                e.exc[t] = 1'b0;
              end
            end
          end
        end
        exp_q[i] = e;
      end
    end
    refresh_head();
  endfunction

  // Report handed over to the DUT
  function automatic void accept_report(input rpt_t r);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (exp_q[i].cmt == r.cmt) begin
        exp_q[i].pend = exp_q[i].pend & ~r.slot;
      end
    end
    refresh_head();
  endfunction

  function automatic void send_report(input bit pipe, input rpt_t r);
    if (pipe) pipe1_q.push_back(r);
    else pipe0_q.push_back(r);
    apply_report(r);
  endfunction

  // --------------------
  // Pipes and monitor
  // --------------------
  always @(negedge i_clk) begin
    i_done0_valid = (pipe0_q.size() > 0);
    if (pipe0_q.size() > 0) begin
      i_done0_cmt_id = pipe0_q[0].cmt;
      i_done0_grp_id = pipe0_q[0].slot;
      i_done0_except_valid = pipe0_q[0].exc;
      i_done0_except_cause = pipe0_q[0].cause;
    end
    i_done1_valid = (pipe1_q.size() > 0);
    if (pipe1_q.size() > 0) begin
      i_done1_cmt_id = pipe1_q[0].cmt;
      i_done1_grp_id = pipe1_q[0].slot;
      i_done1_except_valid = pipe1_q[0].exc;
      i_done1_except_cause = pipe1_q[0].cause;
    end
  end

  always @(posedge i_clk) begin
    if (i_done0_valid && o_done0_ready) begin
      accept_report(pipe0_q[0]);
      pipe0_q.delete(0);
    end
    if (i_done1_valid && o_done1_ready) begin
      accept_report(pipe1_q[0]);
      pipe1_q.delete(0);
    end
    m_in_flush = 1'b0;
    if (i_reset_n && o_commit_valid && i_commit_ready && exp_q.size() > 0) begin
      if (exp_flush) begin
        m_tail = (int'(exp_head.cmt) + 1) % ROB_DEPTH;   // Tail snaps back to new head
        exp_q.delete();
        m_in_flush = 1'b1;
      end else begin
        exp_q.delete(0);
      end
      refresh_head();
    end
  end

  a_commit_match: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_commit_valid && i_commit_ready) |-> (m_count > 0 && exp_head.pend == '0
      && o_commit_cmt_id == exp_head.cmt
      && o_commit_pc == exp_head.pc && o_commit_grp_id == exp_head.grp
      && o_commit_dead_grp == exp_head.dead && o_commit_except_valid == exp_head.exc
      && o_commit_except_cause == exp_cause && o_commit_flush == exp_flush))
    else begin
      $display("MISMATCH at %0t: commit id %0d pc %h grp %b dead %b exc %b cause %0d flush %b",
               $time, $sampled(o_commit_cmt_id), $sampled(o_commit_pc),
               $sampled(o_commit_grp_id), $sampled(o_commit_dead_grp),
               $sampled(o_commit_except_valid), $sampled(o_commit_except_cause),
               $sampled(o_commit_flush));
      err_count++;
    end

  a_commit_hold: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_commit_valid && !i_commit_ready) |=> (o_commit_valid && $stable(o_commit_cmt_id)
      && $stable(o_commit_pc) && $stable(o_commit_grp_id) && $stable(o_commit_dead_grp)
      && $stable(o_commit_except_valid) && $stable(o_commit_except_cause)
      && $stable(o_commit_flush)))
    else begin
      $display("MISMATCH at %0t: commit outputs moved while ready was low", $time);
      err_count++;
    end

  a_disp_ready: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_disp_ready == (m_count < ROB_DEPTH && !m_in_flush))
    else begin
      $display("MISMATCH at %0t: disp_ready %b with %0d groups outstanding, flush %b",
               $time, $sampled(o_disp_ready), $sampled(m_count), $sampled(m_in_flush));
      err_count++;
    end

  a_flush_quiet: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    m_in_flush |-> !o_commit_valid)
    else begin
      $display("MISMATCH at %0t: commit offered during flush", $time);
      err_count++;
    end

  // Pending reports always get a grant
  a_grant_any: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_done0_valid || i_done1_valid) |-> (o_done0_ready || o_done1_ready))
    else begin
      $display("MISMATCH at %0t: completion report pending without a grant", $time);
      err_count++;
    end

  a_alternate0: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_done0_valid && i_done1_valid && o_done0_ready) ##1 (i_done0_valid && i_done1_valid)
      |-> o_done1_ready)
    else begin
      $display("MISMATCH at %0t: pipe 0 granted twice under contention", $time);
      err_count++;
    end

  a_alternate1: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (i_done0_valid && i_done1_valid && o_done1_ready) ##1 (i_done0_valid && i_done1_valid)
      |-> o_done0_ready)
    else begin
      $display("MISMATCH at %0t: pipe 1 granted twice under contention", $time);
      err_count++;
    end

  // --------------------
  // Stimulus helpers
  // --------------------
  task automatic report_timeout(input string what);
    $display("Timeout at %0t: %s did not finish within %0d cycles", $time, what, TIMEOUT);
    err_count++;
    aborted = 1'b1;
  endtask

  task automatic dispatch(input pc_t pc, input grp_id_t grp, input grp_id_t exc,
                          input cause_t cause);
    int cyc;
    if (aborted) return;
    @(negedge i_clk);
    i_disp_valid = 1'b1;
    i_disp_pc = pc;
    i_disp_grp_id = grp;
    i_disp_except_valid = exc;
    i_disp_except_cause = cause;
    cyc = 0;
    @(posedge i_clk);
    while (!o_disp_ready) begin
      cyc++;
      if (cyc > TIMEOUT) begin
        report_timeout("dispatch handshake");
        i_disp_valid = 1'b0;
        return;
      end
      @(posedge i_clk);
    end
    exp_q.push_back(expected_on_dispatch(pc, grp, exc, cause));
    m_tail = (m_tail + 1) % ROB_DEPTH;
    refresh_head();
    @(negedge i_clk);
    i_disp_valid = 1'b0;
  endtask

  // Waits for the pipes to empty, and for all commits too when asked
  task automatic wait_drained(input string what, input bit with_commits);
    int cyc;
    if (aborted) return;
    cyc = 0;
    while (pipe0_q.size() != 0 || pipe1_q.size() != 0
           || (with_commits && exp_q.size() != 0)) begin
      @(posedge i_clk);
      cyc++;
      if (cyc > TIMEOUT) begin
        report_timeout(what);
        return;
      end
    end
    @(negedge i_clk);
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != test_err_start) begin
      tests_failed++;
      $display("%-28s FAIL", name);
    end else begin
      $display("%-28s ok", name);
    end
    test_err_start = err_count;
  endtask

  function automatic cause_t pick_cause();
    int idx;
    idx = take_bits(2) % 3;
    return (idx == 0) ? CAUSE_ILLEGAL : (idx == 1) ? CAUSE_LOAD_FAULT : CAUSE_STORE_FAULT;
  endfunction

  // --------------------
  // Tests
  // --------------------
  task automatic test_in_order();
    rpt_t    rpts[$];
    rpt_t    tmp;
    grp_id_t grp;
    int      j;
    for (int g = 0; g < ROB_DEPTH; g++) begin
      grp = take_bits(2);
      if (grp == '0) grp = 2'b11;
      dispatch(take_bits(32) & ~32'h3, grp, '0, '0);
      if (aborted) return;
      for (int s = 0; s < DISP_SIZE; s++) begin
        if (grp[s]) rpts.push_back(rpt_t'{cmt: exp_q[$].cmt, slot: grp_id_t'(1 << s),
                                           exc: 1'b0, cause: '0});
      end
    end
    for (int i = rpts.size() - 1; i > 0; i--) begin   // Shuffle report order
      j = take_bits(3) % (i + 1);
      tmp = rpts[i];
      rpts[i] = rpts[j];
      rpts[j] = tmp;
    end
    foreach (rpts[i]) send_report(take_bits(1), rpts[i]);
    wait_drained("in-order retirement", 1'b1);
  endtask

  task automatic test_arbitration();
    for (int g = 0; g < ROB_DEPTH; g++) dispatch(take_bits(32) & ~32'h3, 2'b11, '0, '0);
    if (aborted) return;
    foreach (exp_q[i]) begin
      send_report(1'b0, '{cmt: exp_q[i].cmt, slot: 2'b01, exc: 1'b0, cause: '0});
      send_report(1'b1, '{cmt: exp_q[i].cmt, slot: 2'b10, exc: 1'b0, cause: '0});
    end
    wait_drained("contended completions", 1'b1);
  endtask

  task automatic test_exec_exception();
    cmt_id_t older, younger;
    dispatch(take_bits(32) & ~32'h3, 2'b11, '0, '0);
    dispatch(take_bits(32) & ~32'h3, 2'b11, '0, '0);
    if (aborted) return;
    older = exp_q[0].cmt;
    younger = exp_q[1].cmt;
    send_report(1'b1, '{cmt: younger, slot: 2'b01, exc: 1'b0, cause: '0});
    wait_drained("younger group report", 1'b0);
    send_report(1'b0, '{cmt: older, slot: 2'b01, exc: 1'b1, cause: pick_cause()});
    wait_drained("excepting commit", 1'b1);
    // Next commit must be a group dispatched after the flush
    dispatch(take_bits(32) & ~32'h3, 2'b01, '0, '0);
    if (aborted) return;
    send_report(1'b1, '{cmt: exp_q[0].cmt, slot: 2'b01, exc: 1'b0, cause: '0});
    wait_drained("group after flush", 1'b1);
  endtask

  task automatic test_disp_exception();
    dispatch(take_bits(32) & ~32'h3, 2'b11, 2'b11, pick_cause());
    wait_drained("dispatch exception commit", 1'b1);
  endtask

  task automatic test_back_pressure();
    i_commit_ready = 1'b0;
    for (int g = 0; g < ROB_DEPTH; g++) dispatch(take_bits(32) & ~32'h3, 2'b01, '0, '0);
    if (aborted) return;
    repeat (4) @(negedge i_clk);   // Full buffer
    foreach (exp_q[i]) send_report(take_bits(1), '{cmt: exp_q[i].cmt, slot: 2'b01,
                                                      exc: 1'b0, cause: '0});
    wait_drained("reports under back-pressure", 1'b0);
    repeat (6) @(negedge i_clk);   // Head held with ready low
    i_commit_ready = 1'b1;
    wait_drained("release of back-pressure", 1'b1);
  endtask

  initial begin
    i_clk = 1'b0;
    i_reset_n = 1'b0;
    i_disp_valid = 1'b0;
    i_disp_pc = '0;
    i_disp_grp_id = '0;
    i_disp_except_valid = '0;
    i_disp_except_cause = '0;
    {i_done0_valid, i_done0_cmt_id, i_done0_grp_id, i_done0_except_valid} = '0;
    {i_done1_valid, i_done1_cmt_id, i_done1_grp_id, i_done1_except_valid} = '0;
    i_done0_except_cause = '0;
    i_done1_except_cause = '0;
    i_commit_ready = 1'b1;
    lfsr_state = 32'hba06e072;
    {m_count, m_tail, err_count, test_err_start, tests_run, tests_failed} = '0;
    m_in_flush = 1'b0;
    aborted = 1'b0;
    refresh_head();
    repeat (8) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;

    assert (!o_commit_valid && !o_commit_flush && !o_done0_ready && !o_done1_ready
            && o_disp_ready)
      else begin
        $display("MISMATCH at %0t: after reset valid %b flush %b ready %b%b disp_ready %b",
                 $time, o_commit_valid, o_commit_flush, o_done0_ready, o_done1_ready,
                 o_disp_ready);
        err_count++;
      end
    finish_test("1 reset values");
    test_in_order();
    finish_test("2 in-order retirement");
    test_arbitration();
    finish_test("3 arbitration");
    test_exec_exception();
    finish_test("4 execution exception");
    test_disp_exception();
    finish_test("5 dispatch exception");
    test_back_pressure();
    finish_test("6 back-pressure");

    $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
